// File: logic/if_pkg.sv
// instruction fetch stage shared definitions
// fetch address selectors, trap target selectors, the fetched word
// with its two decodings, and the address layout constants

package if_pkg;

  ////////////////////
  // address layout
  ////////////////////

  // datapath address width
  localparam int unsigned ADDR_W = 32;

  // low bits cleared for the vectored and boot bases
  localparam int unsigned VEC_ALIGN_BITS = 8;

  // low byte of the boot fetch address
  localparam logic [7:0] BOOT_OFFSET = 8'h80;

  // interrupt id bits taken from the cause
  localparam int unsigned IRQ_ID_W = 5;

  ////////////////////
  // selectors
  ////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap target inside the exception vector mux
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////
  // fetched word
  ////////////////////

  // two 16 bit parcels, lower one is the compressed instruction
  typedef struct packed {
    logic [15:0] upper;
    logic [15:0] lower;
  } fetch_halves_t;

  // same fetch word seen as a full instruction or as two halves
  typedef union packed {
    logic [31:0]   instr;
    fetch_halves_t halves;
  } fetch_word_u;

endpackage

// File: logic/if_fetch_if.sv
// checked fetch word bundle
// carries one fetch word, its address and its merged fault flags
// from the fault checker to the ID registers and control

`timescale 1ns/100ps

interface if_fetch_if;
  import if_pkg::*;

  // word presented by the prefetch buffer this cycle
  logic              valid;
  fetch_word_u       word;
  logic [ADDR_W-1:0] addr;
  // low two bits not both set
  logic              is_compressed;
  // merged bus, PMP and capability faults
  logic              err;
  logic              err_plus2;
  // capability faults, kept apart for the ID stage
  logic              acc_vio;
  logic              bound_vio;

  // driven by the fault checker
  modport producer (
    output valid, word, addr, is_compressed, err, err_plus2, acc_vio, bound_vio
  );

  // read by the ID registers, control and the PC check
  modport consumer (
    input valid, word, addr, is_compressed, err, err_plus2, acc_vio, bound_vio
  );

endinterface

// File: logic/if_ctrl.sv
// fetch stage control
// answers the prefetch buffer, raises the IF-ID write enable and
// keeps the valid and new flags of the word held in ID

`timescale 1ns/100ps

module if_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  if_fetch_if.consumer      fetch,
  input  logic              id_in_ready_i,
  input  logic              pc_set_i,
  input  if_pkg::pc_sel_e   pc_mux_i,
  input  logic              instr_valid_clear_i,
  output logic              fetch_ready_o,
  output logic              branch_o,
  output logic              csr_mtvec_init_o,
  output logic              pipe_we_o,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o
);
  import if_pkg::*;

  logic instr_valid_id_d;

  // ID back-pressure goes straight to the prefetch buffer
  assign fetch_ready_o = id_in_ready_i;

  // any PC set redirects the prefetch buffer
  assign branch_o = pc_set_i;

  // mtvec gets its reset value when the core boots
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // accept, the IF-ID registers load on this
  assign pipe_we_o = fetch.valid & id_in_ready_i;

  // an incoming pc set squashes the word being accepted
  // valid is then held until ID clears it
  assign instr_valid_id_d = (pipe_we_o & ~pc_set_i) |
                            (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= instr_valid_id_d;
      // new only for the cycle after an accept
      instr_new_id_o   <= pipe_we_o;
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  // a new word in ID always comes from an accept on the edge before
  a_new_needs_accept : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !pipe_we_o |=> !instr_new_id_o
  ) else $error("instr_new_id_o without a preceding accept");

endmodule

// File: logic/pc_select.sv
// next fetch address selection
// builds the trap vector from mtvec or the debug entries, then picks
// the redirect address among boot, jump, trap, mret and dret

`timescale 1ns/100ps

module pc_select #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A110808
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      pc_set_i,
  input  logic [if_pkg::ADDR_W-1:0] boot_addr_i,
  input  if_pkg::pc_sel_e           pc_mux_i,
  input  if_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  logic [5:0]                exc_cause_i,
  input  logic                      cheri_pmode_i,
  input  logic [if_pkg::ADDR_W-1:0] branch_target_ex_i,
  input  logic [if_pkg::ADDR_W-1:0] csr_mepc_i,
  input  logic [if_pkg::ADDR_W-1:0] csr_depc_i,
  input  logic [if_pkg::ADDR_W-1:0] csr_mtvec_i,
  output logic [if_pkg::ADDR_W-1:0] branch_addr_o
);
  import if_pkg::*;

  logic              vec_mode;
  logic [ADDR_W-1:0] vec_base;
  logic [ADDR_W-1:0] irq_offs;
  logic [ADDR_W-1:0] boot_pc;
  logic [ADDR_W-1:0] exc_pc;
  logic [ADDR_W-1:0] fetch_addr_n;

  // 256 byte aligned table, also used whenever capability mode is off
  assign vec_mode = csr_mtvec_i[0] | ~cheri_pmode_i;
  assign vec_base = {csr_mtvec_i[ADDR_W-1:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  // one word per interrupt id, cause msb only marks interrupt
  assign irq_offs = ADDR_W'(exc_cause_i[IRQ_ID_W-1:0]) << 2;
  assign boot_pc  = {boot_addr_i[ADDR_W-1:VEC_ALIGN_BITS], BOOT_OFFSET};

  // trap target
  always_comb begin
    exc_pc = {csr_mtvec_i[ADDR_W-1:2], 2'b00};
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = vec_mode ? vec_base : {csr_mtvec_i[ADDR_W-1:2], 2'b00};
      EXC_PC_IRQ:     exc_pc = vec_mode ? vec_base + irq_offs
                                        : {csr_mtvec_i[ADDR_W-1:2], 2'b00};
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = vec_base;
    endcase
  end

  // redirect address
  always_comb begin
    case (pc_mux_i)
      PC_BOOT: fetch_addr_n = boot_pc;
      PC_JUMP: fetch_addr_n = branch_target_ex_i;
      PC_EXC:  fetch_addr_n = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = boot_pc;
    endcase
  end

  // fetches are halfword aligned
  assign branch_addr_o = {fetch_addr_n[ADDR_W-1:1], 1'b0};

  ////////////////////
  // assertions
  ////////////////////

  a_boot_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[VEC_ALIGN_BITS-1:0] == '0
  ) else $error("boot address not 256 byte aligned");

  a_mux_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown(pc_mux_i)
  ) else $error("pc_mux_i unknown during pc set");

endmodule

// File: logic/fetch_check.sv
// fetch word checker
// flags compressed words and merges bus, PMP and program counter
// capability faults for the word offered by the prefetch buffer

`timescale 1ns/100ps

module fetch_check (
  input  logic                      cheri_pmode_i,
  input  logic                      debug_mode_i,
  input  logic                      fetch_valid_i,
  input  logic [31:0]               fetch_rdata_i,
  input  logic [if_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                      fetch_err_i,
  input  logic                      fetch_err_plus2_i,
  input  logic                      pmp_err_if_i,
  input  logic                      pmp_err_if_plus2_i,
  input  logic [if_pkg::ADDR_W:0]   pcc_top_i,
  input  logic [if_pkg::ADDR_W-1:0] pcc_base_i,
  input  logic                      pcc_perm_ex_i,
  input  logic                      pcc_valid_i,
  input  logic [3:0]                pcc_otype_i,
  if_fetch_if.producer              fetch,
  output logic [if_pkg::ADDR_W-1:0] pc_if_o
);
  import if_pkg::*;

  fetch_word_u       word;
  logic              is_c;
  logic              pmp_err_plus2;
  logic              chk_en;
  logic [ADDR_W+1:0] hdrm;
  logic              hdrm_ge2;
  logic              hdrm_ge4;
  logic              bound_vio;
  logic              acc_vio;

  assign word = fetch_rdata_i;
  // no expansion, only the two low bits are looked at
  assign is_c = word.halves.lower[1:0] != 2'b11;

  // full word straddling a word boundary, second half denied by PMP
  assign pmp_err_plus2 = fetch_addr_i[1] & ~is_c & pmp_err_if_plus2_i;

  ////////////////////
  // pcc checks
  ////////////////////

  // capability checks off in debug mode
  assign chk_en = cheri_pmode_i & ~debug_mode_i;

  // room left below top, a negative result shows in the msb
  assign hdrm     = {1'b0, pcc_top_i} - {2'b00, fetch_addr_i};
  assign hdrm_ge4 = (|hdrm[ADDR_W:2]) & ~hdrm[ADDR_W+1];
  assign hdrm_ge2 = (|hdrm[ADDR_W:1]) & ~hdrm[ADDR_W+1];

  assign bound_vio = chk_en & ((fetch_addr_i < pcc_base_i) | ~(is_c ? hdrm_ge2 : hdrm_ge4));

  // execute permission, tag and seal
  assign acc_vio = chk_en & (~pcc_perm_ex_i | ~pcc_valid_i | (pcc_otype_i != 4'd0));

  ////////////////////
  // outputs
  ////////////////////

  assign fetch.valid         = fetch_valid_i;
  assign fetch.word          = word;
  assign fetch.addr          = fetch_addr_i;
  assign fetch.is_compressed = is_c;
  assign fetch.err           = fetch_err_i | pmp_err_if_i | pmp_err_plus2 | bound_vio | acc_vio;
  // a first half PMP fault wins over any second half fault
  assign fetch.err_plus2     = (pmp_err_plus2 | fetch_err_plus2_i) & ~pmp_err_if_i;
  assign fetch.acc_vio       = acc_vio;
  assign fetch.bound_vio     = bound_vio;

  assign pc_if_o = fetch_addr_i;

endmodule

// File: logic/if_id_regs.sv
// IF-ID pipeline registers
// capture the checked fetch word, its address and fault flags on
// each accept and hold them while ID stalls

`timescale 1ns/100ps

module if_id_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  if_fetch_if.consumer              fetch,
  input  logic                      pipe_we_i,
  output logic [31:0]               instr_rdata_id_o,
  output logic [15:0]               instr_rdata_c_id_o,
  output logic                      instr_is_compressed_id_o,
  output logic                      instr_fetch_err_o,
  output logic                      instr_fetch_err_plus2_o,
  output logic                      instr_fetch_cheri_acc_vio_o,
  output logic                      instr_fetch_cheri_bound_vio_o,
  output logic [if_pkg::ADDR_W-1:0] pc_id_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o              <= '0;
      instr_rdata_c_id_o            <= '0;
      instr_is_compressed_id_o      <= 1'b0;
      instr_fetch_err_o             <= 1'b0;
      instr_fetch_err_plus2_o       <= 1'b0;
      instr_fetch_cheri_acc_vio_o   <= 1'b0;
      instr_fetch_cheri_bound_vio_o <= 1'b0;
      pc_id_o                       <= '0;
    end else if (pipe_we_i) begin
      // full view for the decoder
      instr_rdata_id_o              <= fetch.word.instr;
      // compressed view, meaningful for mtval only on compressed words
      instr_rdata_c_id_o            <= fetch.word.halves.lower;
      instr_is_compressed_id_o      <= fetch.is_compressed;
      // fault flags travel with their word
      instr_fetch_err_o             <= fetch.err;
      instr_fetch_err_plus2_o       <= fetch.err_plus2;
      instr_fetch_cheri_acc_vio_o   <= fetch.acc_vio;
      instr_fetch_cheri_bound_vio_o <= fetch.bound_vio;
      pc_id_o                       <= fetch.addr;
    end
  end

endmodule

// File: logic/pc_incr_check.sv
// sequential fetch address check
// raises an alert when the word after an accepted one is not at the
// accepted address plus its length, unless a redirect or fault intervened

`timescale 1ns/100ps

module pc_incr_check (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  if_fetch_if.consumer              fetch,
  input  logic                      pipe_we_i,
  input  logic                      pc_set_i,
  input  logic [if_pkg::ADDR_W-1:0] pc_id_i,
  input  logic                      is_compressed_id_i,
  output logic                      pc_mismatch_alert_o
);

  logic                      seq_q;
  logic                      seq_d;
  logic [if_pkg::ADDR_W-1:0] pc_incr;

  // no check after a redirect, after a faulting fetch or out of reset
  assign seq_d = (seq_q | pipe_we_i) & ~pc_set_i & ~fetch.err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // expected next fetch address
  assign pc_incr = pc_id_i + (is_compressed_id_i ? 32'd2 : 32'd4);

  assign pc_mismatch_alert_o = seq_q & (fetch.addr != pc_incr);

  // the alert needs an accept first, so none right out of reset
  a_no_alert_after_reset : assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !pc_mismatch_alert_o
  ) else $error("pc mismatch alert right after reset");

endmodule

// File: logic/if_stage_top.sv
// instruction fetch stage
// next PC selection, fault merging and IF-ID registers for a core
// with capability checks; the prefetch buffer sits outside

`timescale 1ns/100ps

module if_stage_top #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A110808
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cheri_pmode_i,
  input  logic                      debug_mode_i,
  input  logic [if_pkg::ADDR_W-1:0] boot_addr_i,
  // redirect control
  input  logic                      pc_set_i,
  input  if_pkg::pc_sel_e           pc_mux_i,
  input  if_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  logic [5:0]                exc_cause_i,
  input  logic [if_pkg::ADDR_W-1:0] branch_target_ex_i,
  input  logic [if_pkg::ADDR_W-1:0] csr_mepc_i,
  input  logic [if_pkg::ADDR_W-1:0] csr_depc_i,
  input  logic [if_pkg::ADDR_W-1:0] csr_mtvec_i,
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  // prefetch buffer side
  input  logic                      fetch_valid_i,
  input  logic [31:0]               fetch_rdata_i,
  input  logic [if_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                      fetch_err_i,
  input  logic                      fetch_err_plus2_i,
  output logic                      fetch_ready_o,
  output logic                      branch_o,
  output logic [if_pkg::ADDR_W-1:0] branch_addr_o,
  // PMP and program counter capability
  input  logic                      pmp_err_if_i,
  input  logic                      pmp_err_if_plus2_i,
  input  logic [if_pkg::ADDR_W:0]   pcc_top_i,
  input  logic [if_pkg::ADDR_W-1:0] pcc_base_i,
  input  logic                      pcc_perm_ex_i,
  input  logic                      pcc_valid_i,
  input  logic [3:0]                pcc_otype_i,
  // ID stage side
  output logic                      csr_mtvec_init_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic [31:0]               instr_rdata_id_o,
  output logic [15:0]               instr_rdata_c_id_o,
  output logic                      instr_is_compressed_id_o,
  output logic                      instr_fetch_err_o,
  output logic                      instr_fetch_err_plus2_o,
  output logic                      instr_fetch_cheri_acc_vio_o,
  output logic                      instr_fetch_cheri_bound_vio_o,
  output logic [if_pkg::ADDR_W-1:0] pc_if_o,
  output logic [if_pkg::ADDR_W-1:0] pc_id_o,
  output logic                      pc_mismatch_alert_o
);

  logic pipe_we;

  if_fetch_if fetch_bus ();

  if_ctrl ctrl_i (
    .clk_i, .rst_ni, .fetch(fetch_bus.consumer), .id_in_ready_i, .pc_set_i, .pc_mux_i,
    .instr_valid_clear_i, .fetch_ready_o, .branch_o, .csr_mtvec_init_o,
    .pipe_we_o(pipe_we), .instr_valid_id_o, .instr_new_id_o
  );

  pc_select #(
    .DmHaltAddr     (DmHaltAddr),
    .DmExceptionAddr(DmExceptionAddr)
  ) pc_select_i (
    .clk_i, .rst_ni, .pc_set_i, .boot_addr_i, .pc_mux_i, .exc_pc_mux_i, .exc_cause_i,
    .cheri_pmode_i, .branch_target_ex_i, .csr_mepc_i, .csr_depc_i, .csr_mtvec_i,
    .branch_addr_o
  );

  fetch_check fetch_check_i (
    .cheri_pmode_i, .debug_mode_i, .fetch_valid_i, .fetch_rdata_i, .fetch_addr_i,
    .fetch_err_i, .fetch_err_plus2_i, .pmp_err_if_i, .pmp_err_if_plus2_i, .pcc_top_i,
    .pcc_base_i, .pcc_perm_ex_i, .pcc_valid_i, .pcc_otype_i,
    .fetch(fetch_bus.producer), .pc_if_o
  );

  if_id_regs if_id_regs_i (
    .clk_i, .rst_ni, .fetch(fetch_bus.consumer), .pipe_we_i(pipe_we), .instr_rdata_id_o,
    .instr_rdata_c_id_o, .instr_is_compressed_id_o, .instr_fetch_err_o,
    .instr_fetch_err_plus2_o, .instr_fetch_cheri_acc_vio_o, .instr_fetch_cheri_bound_vio_o,
    .pc_id_o
  );

  // compares against the registered ID address and length
  pc_incr_check pc_incr_check_i (
    .clk_i, .rst_ni, .fetch(fetch_bus.consumer), .pipe_we_i(pipe_we), .pc_set_i,
    .pc_id_i(pc_id_o), .is_compressed_id_i(instr_is_compressed_id_o), .pc_mismatch_alert_o
  );

endmodule

// File: verif/tb_if_stage.sv
// fetch stage testbench
// random stimulus from an LFSR, checked every cycle against a model of
// the PC selection, fault merging, IF-ID registers and PC check

`timescale 1ns/100ps

module tb_if_stage;
  import if_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_CYCLES   = 4000;
  // test length plus some slack
  localparam int WATCHDOG_NS = (RST_CYCLES + N_CYCLES + 50) * CLK_PERIOD;
  // debug entries away from the module defaults
  localparam logic [31:0] DM_HALT = 32'h0000_4A00;
  localparam logic [31:0] DM_EXC  = 32'h0000_4A08;

  logic clk_i, rst_ni, cheri_pmode_i, debug_mode_i, pc_set_i, id_in_ready_i;
  logic instr_valid_clear_i, fetch_valid_i, fetch_err_i, fetch_err_plus2_i;
  logic pmp_err_if_i, pmp_err_if_plus2_i, pcc_perm_ex_i, pcc_valid_i;
  logic [31:0] boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic [31:0] fetch_rdata_i, fetch_addr_i, pcc_base_i;
  logic [32:0] pcc_top_i;
  logic [5:0]  exc_cause_i;
  logic [3:0]  pcc_otype_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic fetch_ready_o, branch_o, csr_mtvec_init_o, instr_valid_id_o, instr_new_id_o;
  logic instr_is_compressed_id_o, instr_fetch_err_o, instr_fetch_err_plus2_o;
  logic instr_fetch_cheri_acc_vio_o, instr_fetch_cheri_bound_vio_o, pc_mismatch_alert_o;
  logic [31:0] branch_addr_o, instr_rdata_id_o, pc_if_o, pc_id_o;
  logic [15:0] instr_rdata_c_id_o;

  // model of the ID side state
  logic m_valid, m_new, m_is_c, m_err, m_err2, m_acc, m_bound, m_seq;
  fetch_word_u m_word;
  logic [31:0] m_pc_id;

  logic [15:0] lfsr_state;
  int addr_errs, word_errs, flag_errs;

  if_stage_top #(
    .DmHaltAddr     (DM_HALT),
    .DmExceptionAddr(DM_EXC)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // random source
  ////////////////////

  // taps x^16 + x^14 + x^13 + x^11 + 1
  // one step per bit
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_addr(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
      addr_errs++;
    end
  endtask

  task automatic check_word(input string what, input fetch_word_u got, input fetch_word_u exp);
    if (got !== exp) begin
      $display("Fail %0t: %s is %h, expected %h", $time, what, got.instr, exp.instr);
      word_errs++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
      flag_errs++;
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // redirect target straight from the selection rules
  function automatic logic [31:0] expected_fetch_addr();
    logic [31:0] vec;
    logic [31:0] tgt;
    if (csr_mtvec_i[0] || !cheri_pmode_i) begin
      vec = csr_mtvec_i & 32'hFFFF_FF00;
      if (exc_pc_mux_i == EXC_PC_IRQ) begin
        vec = vec + {25'd0, exc_cause_i[4:0], 2'b00};
      end
    end else begin
      vec = csr_mtvec_i & 32'hFFFF_FFFC;
    end
    if (exc_pc_mux_i == EXC_PC_DBD) vec = DM_HALT;
    if (exc_pc_mux_i == EXC_PC_DBG_EXC) vec = DM_EXC;
    case (pc_mux_i)
      PC_JUMP: tgt = branch_target_ex_i;
      PC_EXC:  tgt = vec;
      PC_ERET: tgt = csr_mepc_i;
      PC_DRET: tgt = csr_depc_i;
      default: tgt = (boot_addr_i & 32'hFFFF_FF00) | 32'h0000_0080;
    endcase
    return tgt & 32'hFFFF_FFFE;
  endfunction

  // advance the model by one rising edge with the current inputs
  task automatic update_model();
    logic acc_in, c, chk, pmp2, bound, acc, err;
    longint room;
    acc_in = fetch_valid_i & id_in_ready_i;
    c      = fetch_rdata_i[1:0] != 2'b11;
    chk    = cheri_pmode_i & ~debug_mode_i;
    pmp2   = fetch_addr_i[1] & ~c & pmp_err_if_plus2_i;
    // signed headroom goes negative past top
    room   = longint'(pcc_top_i) - longint'(fetch_addr_i);
    bound  = chk & ((fetch_addr_i < pcc_base_i) || (room < (c ? 64'sd2 : 64'sd4)));
    acc    = chk & (!pcc_perm_ex_i || !pcc_valid_i || pcc_otype_i != 4'd0);
    err    = fetch_err_i | pmp_err_if_i | pmp2 | bound | acc;
    m_seq   = (m_seq | acc_in) & ~pc_set_i & ~err;
    m_valid = (acc_in & ~pc_set_i) | (m_valid & ~instr_valid_clear_i);
    m_new   = acc_in;
    if (acc_in) begin
      m_word  = fetch_rdata_i;
      m_is_c  = c;
      m_err   = err;
      m_err2  = (pmp2 | fetch_err_plus2_i) & ~pmp_err_if_i;
      m_acc   = acc;
      m_bound = bound;
      m_pc_id = fetch_addr_i;
    end
  endtask

  ////////////////////
  // stimulus and checks
  ////////////////////

  task automatic drive_inputs();
    logic [31:0] r;
    // mostly sequential addresses so the PC check has quiet stretches
    r = rand_bits(2);
    if (r[1:0] != 2'b00) begin
      fetch_addr_i = m_pc_id + (m_is_c ? 32'd2 : 32'd4);
    end else begin
      r = rand_bits(31);
      fetch_addr_i = {r[30:0], 1'b0};
    end
    fetch_valid_i      = next_bit();
    id_in_ready_i      = rand_bits(2) != 0;
    fetch_rdata_i      = rand_bits(32);
    fetch_err_i        = rand_bits(3) == 0;
    fetch_err_plus2_i  = rand_bits(3) == 0;
    pmp_err_if_i       = rand_bits(3) == 0;
    pmp_err_if_plus2_i = rand_bits(2) == 0;
    cheri_pmode_i      = rand_bits(2) != 0;
    debug_mode_i       = rand_bits(2) == 0;
    // bounds placed around the address to hit the edge cases
    r = rand_bits(4);
    pcc_base_i = fetch_addr_i - r + 32'd2;
    // top may also sit below the address
    r = rand_bits(4);
    pcc_top_i = {1'b0, fetch_addr_i} + {1'b0, r} - 33'd6;
    pcc_perm_ex_i = rand_bits(3) != 0;
    pcc_valid_i   = rand_bits(3) != 0;
    r = rand_bits(4);
    pcc_otype_i = (rand_bits(3) == 0) ? r[3:0] : 4'd0;
    pc_set_i = rand_bits(2) == 0;
    r = rand_bits(3);
    if (r > 4) r = r - 4;
    pc_mux_i = pc_sel_e'(r[2:0]);
    r = rand_bits(2);
    exc_pc_mux_i = exc_pc_sel_e'(r[1:0]);
    r = rand_bits(6);
    exc_cause_i = r[5:0];
    r = rand_bits(24);
    boot_addr_i         = {r[23:0], 8'h00};
    csr_mtvec_i         = rand_bits(32);
    csr_mepc_i          = rand_bits(32);
    csr_depc_i          = rand_bits(32);
    branch_target_ex_i  = rand_bits(32);
    instr_valid_clear_i = rand_bits(3) == 0;
  endtask

  task automatic check_outputs();
    logic [31:0] next_pc;
    next_pc = m_pc_id + (m_is_c ? 32'd2 : 32'd4);
    check_flag("fetch_ready_o", fetch_ready_o, id_in_ready_i);
    check_flag("branch_o", branch_o, pc_set_i);
    check_addr("branch_addr_o", branch_addr_o, expected_fetch_addr());
    check_flag("csr_mtvec_init_o", csr_mtvec_init_o, pc_set_i && pc_mux_i == PC_BOOT);
    check_addr("pc_if_o", pc_if_o, fetch_addr_i);
    check_flag("instr_valid_id_o", instr_valid_id_o, m_valid);
    check_flag("instr_new_id_o", instr_new_id_o, m_new);
    check_word("instr_rdata_id_o", instr_rdata_id_o, m_word);
    check_word("instr_rdata_c_id_o", {16'h0000, instr_rdata_c_id_o},
               {16'h0000, m_word.instr[15:0]});
    check_flag("instr_is_compressed_id_o", instr_is_compressed_id_o, m_is_c);
    check_flag("instr_fetch_err_o", instr_fetch_err_o, m_err);
    check_flag("instr_fetch_err_plus2_o", instr_fetch_err_plus2_o, m_err2);
    check_flag("instr_fetch_cheri_acc_vio_o", instr_fetch_cheri_acc_vio_o, m_acc);
    check_flag("instr_fetch_cheri_bound_vio_o", instr_fetch_cheri_bound_vio_o, m_bound);
    check_addr("pc_id_o", pc_id_o, m_pc_id);
    check_flag("pc_mismatch_alert_o", pc_mismatch_alert_o, m_seq && fetch_addr_i != next_pc);
  endtask

  // everything starts out quiet with the model at its reset state
  task automatic init_all();
    {cheri_pmode_i, debug_mode_i, pc_set_i, id_in_ready_i, instr_valid_clear_i} = '0;
    {fetch_valid_i, fetch_err_i, fetch_err_plus2_i, pmp_err_if_i, pmp_err_if_plus2_i} = '0;
    {pcc_perm_ex_i, pcc_valid_i, pcc_top_i, pcc_base_i, pcc_otype_i, exc_cause_i} = '0;
    {boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i} = '0;
    {fetch_rdata_i, fetch_addr_i} = '0;
    pc_mux_i     = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    {m_valid, m_new, m_is_c, m_err, m_err2, m_acc, m_bound, m_seq} = '0;
    m_word  = '0;
    m_pc_id = '0;
  endtask

  initial begin
    rst_ni = 1'b0;
    lfsr_state = 16'd36237;
    addr_errs = 0;
    word_errs = 0;
    flag_errs = 0;
    init_all();
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    // model still holds its reset state here
    check_outputs();
    rst_ni = 1'b1;
    for (int i = 0; i < N_CYCLES; i++) begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      check_outputs();
      update_model();
    end
    $display("error counts: address %0d, word %0d, flag %0d", addr_errs, word_errs, flag_errs);
    if (addr_errs + word_errs + flag_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // stops a stuck run
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test loop finished");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: sim.f
logic/if_pkg.sv
logic/if_fetch_if.sv
logic/if_ctrl.sv
logic/pc_select.sv
logic/fetch_check.sv
logic/if_id_regs.sv
logic/pc_incr_check.sv
logic/if_stage_top.sv
verif/tb_if_stage.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_if_stage \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_if_stage)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
